/* verilog/proc_ctrl_pkg.sv */
// ------------------------------
// processor control package
// select encodings, control words, instruction patterns
// ------------------------------
package proc_ctrl_pkg;

  // basic fields
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  // ------------------------------
  // datapath selects
  // ------------------------------

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or,
    alu_xor, alu_slt, alu_sltu, alu_sra,
    alu_srl, alu_sll, alu_cp0, alu_cp1
  } alu_fn_e;

  // csr operand is the mngr2proc value
  typedef enum logic [1:0] {
    op2_rf, op2_imm, op2_csr
  } op2_sel_e;

  // encoding kept in step with the immediate generator
  typedef enum logic [2:0] {
    imm_i = 3'd0,
    imm_b = 3'd2
  } imm_type_e;

  typedef enum logic [1:0] {
    br_none, br_bne, br_beq
  } br_type_e;

  typedef enum logic {
    mem_none, mem_load
  } mem_type_e;

  typedef enum logic {
    wb_alu, wb_mem
  } wb_sel_e;

  typedef enum logic [1:0] {
    pc_plus4, pc_branch
  } pc_sel_e;

  // ------------------------------
  // control words
  // ------------------------------

  // selects used in D itself
  typedef struct packed {
    op2_sel_e  op2_sel;
    imm_type_e imm_type;
  } d_ctrl_t;

  // word carried through X, M and W
  typedef struct packed {
    logic      rf_wen;
    reg_addr_t rf_waddr;
    alu_fn_e   alu_fn;
    br_type_e  br_type;
    mem_type_e mem_type;
    wb_sel_e   wb_sel;
    logic      proc2mngr;
  } x_ctrl_t;

  // per stage register enables to the datapath
  typedef struct packed {
    logic f;
    logic d;
    logic x;
    logic m;
    logic w;
  } reg_en_t;

  // manager csr numbers
  localparam csr_addr_t CSR_PROC2MNGR = 12'h7C0;
  localparam csr_addr_t CSR_MNGR2PROC = 12'hFC0;

  // ------------------------------
  // casez patterns, RV32 field layout
  // ------------------------------

  // nop is addi x0, x0, 0 and must be matched before addi
  localparam inst_t INST_NOP  = 32'b0000000_00000_00000_000_00000_0010011;
  localparam inst_t INST_ADD  = 32'b0000000_?????_?????_000_?????_0110011;
  localparam inst_t INST_SUB  = 32'b0100000_?????_?????_000_?????_0110011;
  localparam inst_t INST_AND  = 32'b0000000_?????_?????_111_?????_0110011;
  localparam inst_t INST_OR   = 32'b0000000_?????_?????_110_?????_0110011;
  localparam inst_t INST_XOR  = 32'b0000000_?????_?????_100_?????_0110011;
  localparam inst_t INST_SLT  = 32'b0000000_?????_?????_010_?????_0110011;
  localparam inst_t INST_SLTU = 32'b0000000_?????_?????_011_?????_0110011;
  localparam inst_t INST_SRA  = 32'b0100000_?????_?????_101_?????_0110011;
  localparam inst_t INST_SRL  = 32'b0000000_?????_?????_101_?????_0110011;
  localparam inst_t INST_SLL  = 32'b0000000_?????_?????_001_?????_0110011;
  localparam inst_t INST_ADDI = 32'b????????????_?????_000_?????_0010011;
  localparam inst_t INST_LW   = 32'b????????????_?????_010_?????_0000011;
  localparam inst_t INST_BNE  = 32'b???????_?????_?????_001_?????_1100011;
  localparam inst_t INST_BEQ  = 32'b???????_?????_?????_000_?????_1100011;
  // csrr is csrrs rd, csr, x0 and csrw is csrrw x0, csr, rs1
  localparam inst_t INST_CSRR = 32'b????????????_00000_010_?????_1110011;
  localparam inst_t INST_CSRW = 32'b????????????_?????_001_00000_1110011;

endpackage

/* verilog/inst_decoder.sv */
// ------------------------------
// instruction decoder
// control table and csr decode for the word in D
// ------------------------------
`timescale 1ns/1ps

module inst_decoder import proc_ctrl_pkg::*; (
  input  inst_t     inst,
  output logic      dec_val,
  output x_ctrl_t   dec,
  output d_ctrl_t   d_ctrl,
  output logic      rs1_en,
  output logic      rs2_en,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output logic      mngr2proc_read
);

  // one row of the decode table
  typedef struct packed {
    logic      val;
    br_type_e  br_type;
    imm_type_e imm_type;
    logic      rs1_en;
    op2_sel_e  op2_sel;
    logic      rs2_en;
    alu_fn_e   alu_fn;
    mem_type_e mem_type;
    wb_sel_e   wb_sel;
    logic      rf_wen;
    logic      csrr;
    logic      csrw;
  } cs_row_t;

  localparam logic n = 1'b0;
  localparam logic y = 1'b1;

  csr_addr_t csr;
  cs_row_t   row;

  // fixed field positions
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign csr = inst[31:20];

  // ------------------------------
  // decode table
  // ------------------------------

  always_comb begin
    casez (inst)
      //                val br       imm    rs1 op2      rs2 alu       mem       wb      wen rd wr
      INST_NOP  : row = '{y, br_none, imm_i, n, op2_rf,  n, alu_add,  mem_none, wb_alu, n, n, n};
      INST_ADD  : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_add,  mem_none, wb_alu, y, n, n};
      INST_SUB  : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_sub,  mem_none, wb_alu, y, n, n};
      INST_AND  : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_and,  mem_none, wb_alu, y, n, n};
      INST_OR   : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_or,   mem_none, wb_alu, y, n, n};
      INST_XOR  : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_xor,  mem_none, wb_alu, y, n, n};
      INST_SLT  : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_slt,  mem_none, wb_alu, y, n, n};
      INST_SLTU : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_sltu, mem_none, wb_alu, y, n, n};
      INST_SRA  : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_sra,  mem_none, wb_alu, y, n, n};
      INST_SRL  : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_srl,  mem_none, wb_alu, y, n, n};
      INST_SLL  : row = '{y, br_none, imm_i, y, op2_rf,  y, alu_sll,  mem_none, wb_alu, y, n, n};
      // reg-imm and load
      INST_ADDI : row = '{y, br_none, imm_i, y, op2_imm, n, alu_add,  mem_none, wb_alu, y, n, n};
      INST_LW   : row = '{y, br_none, imm_i, y, op2_imm, n, alu_add,  mem_load, wb_mem, y, n, n};
      // branches compare in the datapath, alu unused
      INST_BNE  : row = '{y, br_bne,  imm_b, y, op2_rf,  y, alu_add,  mem_none, wb_alu, n, n, n};
      INST_BEQ  : row = '{y, br_beq,  imm_b, y, op2_rf,  y, alu_add,  mem_none, wb_alu, n, n, n};
      // csr moves
      INST_CSRR : row = '{y, br_none, imm_i, n, op2_csr, n, alu_cp1,  mem_none, wb_alu, y, y, n};
      INST_CSRW : row = '{y, br_none, imm_i, y, op2_rf,  n, alu_cp0,  mem_none, wb_alu, n, n, y};
      default   : row = '{n, br_none, imm_i, n, op2_rf,  n, alu_add,  mem_none, wb_alu, n, n, n};
    endcase
  end

  // ------------------------------
  // outputs
  // ------------------------------

  assign dec_val = row.val;
  assign rs1_en  = row.rs1_en;
  assign rs2_en  = row.rs2_en;

  // only the manager csrs are kept
  assign mngr2proc_read = row.csrr && (csr == CSR_MNGR2PROC);

  always_comb begin
    d_ctrl.op2_sel  = row.op2_sel;
    d_ctrl.imm_type = row.imm_type;
    // word handed to X
    dec.rf_wen    = row.rf_wen;
    dec.rf_waddr  = inst[11:7];
    dec.alu_fn    = row.alu_fn;
    dec.br_type   = row.br_type;
    dec.mem_type  = row.mem_type;
    dec.wb_sel    = row.wb_sel;
    dec.proc2mngr = row.csrw && (csr == CSR_PROC2MNGR);
  end

endmodule

/* verilog/hazard_detect.sv */
// ------------------------------
// hazard detect
// D sources against pending writes in X, M and W
// ------------------------------
`timescale 1ns/1ps

module hazard_detect import proc_ctrl_pkg::*; (
  input  logic      rs1_en,
  input  logic      rs2_en,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      val_X,
  input  logic      val_M,
  input  logic      val_W,
  input  logic      rf_wen_X,
  input  logic      rf_wen_M,
  input  logic      rf_wen_pend_W,
  input  reg_addr_t rf_waddr_X,
  input  reg_addr_t rf_waddr_M,
  input  reg_addr_t rf_waddr_W,
  output logic      hazard
);

  // x0 never creates a dependence
  function automatic logic pend_match(
    input logic      src_en,
    input reg_addr_t src,
    input logic      val,
    input logic      wen,
    input reg_addr_t waddr
  );
    return src_en && val && wen && (waddr != 5'd0) && (src == waddr);
  endfunction

  logic hit_rs1;
  logic hit_rs2;

  // no bypass paths, so every later stage counts
  assign hit_rs1 = pend_match(rs1_en, rs1, val_X, rf_wen_X, rf_waddr_X)
                || pend_match(rs1_en, rs1, val_M, rf_wen_M, rf_waddr_M)
                || pend_match(rs1_en, rs1, val_W, rf_wen_pend_W, rf_waddr_W);

  assign hit_rs2 = pend_match(rs2_en, rs2, val_X, rf_wen_X, rf_waddr_X)
                || pend_match(rs2_en, rs2, val_M, rf_wen_M, rf_waddr_M)
                || pend_match(rs2_en, rs2, val_W, rf_wen_pend_W, rf_waddr_W);

  assign hazard = hit_rs1 || hit_rs2;

endmodule

/* verilog/stage_ctrl_regs.sv */
// ------------------------------
// stage control registers
// valid bit and control word for X, M and W
// ------------------------------
`timescale 1ns/1ps

module stage_ctrl_regs import proc_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_en_t   reg_en,
  input  x_ctrl_t   dec,
  input  logic      next_val_D,
  input  logic      next_val_X,
  input  logic      next_val_M,
  input  logic      stall_W,
  output x_ctrl_t   x_ctrl,
  output logic      val_X,
  output logic      val_M,
  output logic      val_W,
  output mem_type_e mem_type_M,
  output wb_sel_e   wb_sel_M,
  output logic      proc2mngr_W,
  output logic      rf_wen_X,
  output logic      rf_wen_M,
  output logic      rf_wen_pend_W,
  output reg_addr_t rf_waddr_X,
  output reg_addr_t rf_waddr_M,
  output reg_addr_t rf_waddr_W,
  output logic      rf_wen_W,
  output logic      commit_inst
);

  // index 0 is X, 1 is M, 2 is W
  logic [2:0] en;
  logic [2:0] val;
  logic [2:0] val_in;
  x_ctrl_t    ctrl    [3];
  x_ctrl_t    ctrl_in [3];

  assign en     = {reg_en.w, reg_en.m, reg_en.x};
  assign val_in = {next_val_M, next_val_X, next_val_D};

  // each stage loads from the one before it
  assign ctrl_in[0] = dec;
  assign ctrl_in[1] = ctrl[0];
  assign ctrl_in[2] = ctrl[1];

  // ------------------------------
  // pipeline registers
  // ------------------------------

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (reset) begin
        val[i]  <= 1'b0;
        ctrl[i] <= '0;
      end else if (en[i]) begin
        val[i]  <= val_in[i];
        ctrl[i] <= ctrl_in[i];
      end
    end
  end

  // ------------------------------
  // per stage views
  // ------------------------------

  assign val_X = val[0];
  assign val_M = val[1];
  assign val_W = val[2];

  // X fields for alu and branch resolution
  assign x_ctrl     = ctrl[0];
  assign rf_wen_X   = ctrl[0].rf_wen;
  assign rf_waddr_X = ctrl[0].rf_waddr;

  // M fields
  assign rf_wen_M   = ctrl[1].rf_wen;
  assign rf_waddr_M = ctrl[1].rf_waddr;
  assign mem_type_M = ctrl[1].mem_type;
  assign wb_sel_M   = ctrl[1].wb_sel;

  // W fields
  assign rf_wen_pend_W = ctrl[2].rf_wen;
  assign rf_waddr_W    = ctrl[2].rf_waddr;
  assign proc2mngr_W   = ctrl[2].proc2mngr;

  // register file write only for a live W entry
  assign rf_wen_W    = val_W && rf_wen_pend_W;
  // retires in the cycle W lets it go
  assign commit_inst = val_W && !stall_W;

endmodule

/* verilog/pipe_ctrl.sv */
// ------------------------------
// pipeline control
// F/D valid bits, stall and squash network, branch redirect, port strobes
// ------------------------------
`timescale 1ns/1ps

module pipe_ctrl import proc_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      dec_val,
  input  logic      mngr2proc_read_D,
  input  logic      hazard_D,
  input  x_ctrl_t   x_ctrl,
  input  logic      val_X,
  input  logic      val_M,
  input  logic      val_W,
  input  mem_type_e mem_type_M,
  input  logic      proc2mngr_W,
  input  logic      br_cond_eq_X,
  output logic      imem_reqstream_val,
  input  logic      imem_reqstream_rdy,
  input  logic      imem_respstream_val,
  output logic      imem_respstream_rdy,
  output logic      imem_respstream_drop,
  output logic      dmem_reqstream_val,
  input  logic      dmem_reqstream_rdy,
  input  logic      dmem_respstream_val,
  output logic      dmem_respstream_rdy,
  input  logic      mngr2proc_val,
  output logic      mngr2proc_rdy,
  output logic      proc2mngr_val,
  input  logic      proc2mngr_rdy,
  output reg_en_t   reg_en,
  output pc_sel_e   pc_sel_F,
  output logic      next_val_D,
  output logic      next_val_X,
  output logic      next_val_M,
  output logic      stall_W
);

  logic val_F;
  logic val_D;
  // stalls raised by a stage itself
  logic ostall_F;
  logic ostall_D;
  logic ostall_X;
  logic ostall_M;
  logic ostall_W;
  // stalls including everything ahead
  logic stall_F;
  logic stall_D;
  logic stall_X;
  logic stall_M;
  logic squash_F;
  logic squash_D;
  logic osquash_X;
  logic br_taken_X;
  logic fetch_go;
  logic next_val_F;

  // ------------------------------
  // X branch resolution
  // ------------------------------

  always_comb begin
    case (x_ctrl.br_type)
      br_bne:  br_taken_X = val_X && !br_cond_eq_X;
      br_beq:  br_taken_X = val_X && br_cond_eq_X;
      default: br_taken_X = 1'b0;
    endcase
  end

  // X also holds a taken branch until imem takes the redirect
  assign ostall_X = val_X && ((x_ctrl.mem_type == mem_load && !dmem_reqstream_rdy)
                           || (br_taken_X && !imem_reqstream_rdy));
  assign stall_X  = val_X && (ostall_X || ostall_M || ostall_W);
  // once only, so never while X itself is held
  assign osquash_X = br_taken_X && !stall_X;

  assign dmem_reqstream_val = val_X && !stall_X && (x_ctrl.mem_type == mem_load);
  assign next_val_X         = val_X && !stall_X;

  // ------------------------------
  // M and W
  // ------------------------------

  assign ostall_M = val_M && (mem_type_M == mem_load) && !dmem_respstream_val;
  assign stall_M  = val_M && (ostall_M || ostall_W);
  assign dmem_respstream_rdy = val_M && !stall_M && (mem_type_M == mem_load);
  assign next_val_M = val_M && !stall_M;

  assign ostall_W      = val_W && proc2mngr_W && !proc2mngr_rdy;
  assign stall_W       = ostall_W;
  assign proc2mngr_val = val_W && !stall_W && proc2mngr_W;

  // ------------------------------
  // D
  // ------------------------------

  assign ostall_D = val_D && (hazard_D || (mngr2proc_read_D && !mngr2proc_val));
  assign stall_D  = val_D && (ostall_D || ostall_X || ostall_M || ostall_W);
  assign squash_D = val_D && osquash_X;

  // mngr2proc token only taken when the csrr really leaves D
  assign mngr2proc_rdy = val_D && mngr2proc_read_D && !stall_D && !squash_D;
  // unknown words are dropped here
  assign next_val_D    = val_D && dec_val && !stall_D && !squash_D;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_D <= 1'b0;
    end else if (!stall_D || squash_D) begin
      val_D <= next_val_F;
    end
  end

  // ------------------------------
  // F
  // ------------------------------

  assign ostall_F = val_F && !imem_respstream_val;
  assign stall_F  = val_F && (ostall_F || ostall_D || ostall_X || ostall_M || ostall_W);
  assign squash_F = val_F && osquash_X;
  assign fetch_go = !stall_F || squash_F;

  // request goes out before F, never during reset
  assign imem_reqstream_val   = fetch_go && !reset;
  assign imem_respstream_rdy  = fetch_go;
  assign imem_respstream_drop = squash_F;
  assign pc_sel_F   = osquash_X ? pc_branch : pc_plus4;
  assign next_val_F = val_F && !stall_F && !squash_F;

  // F valid means an accepted fetch is outstanding
  always_ff @(posedge clk) begin
    if (reset) begin
      val_F <= 1'b0;
    end else if (fetch_go) begin
      val_F <= imem_reqstream_rdy;
    end
  end

  // pc only moves when its request was accepted
  always_comb begin
    reg_en.f = fetch_go && imem_reqstream_rdy;
    reg_en.d = !stall_D || squash_D;
    reg_en.x = !stall_X;
    reg_en.m = !stall_M;
    reg_en.w = !stall_W;
  end

endmodule

/* verilog/proc_ctrl.sv */
// ------------------------------
// processor control unit
// five stage in-order control, no bypassing
// ------------------------------
`timescale 1ns/1ps

module proc_ctrl import proc_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // instruction memory
  output logic      imem_reqstream_val,
  input  logic      imem_reqstream_rdy,
  input  logic      imem_respstream_val,
  output logic      imem_respstream_rdy,
  output logic      imem_respstream_drop,
  // data memory
  output logic      dmem_reqstream_val,
  input  logic      dmem_reqstream_rdy,
  input  logic      dmem_respstream_val,
  output logic      dmem_respstream_rdy,
  // manager
  input  logic      mngr2proc_val,
  output logic      mngr2proc_rdy,
  output logic      proc2mngr_val,
  input  logic      proc2mngr_rdy,
  // datapath status
  input  inst_t     inst_D,
  input  logic      br_cond_eq_X,
  // datapath controls
  output reg_en_t   reg_en,
  output pc_sel_e   pc_sel_F,
  output d_ctrl_t   d_ctrl_D,
  output alu_fn_e   alu_fn_X,
  output wb_sel_e   wb_sel_M,
  output reg_addr_t rf_waddr_W,
  output logic      rf_wen_W,
  output logic      commit_inst
);

  // decode outputs
  logic      dec_val;
  x_ctrl_t   dec;
  logic      rs1_en;
  logic      rs2_en;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      mngr2proc_read_D;
  logic      hazard_D;
  // later stage state
  x_ctrl_t   x_ctrl;
  logic      val_X;
  logic      val_M;
  logic      val_W;
  mem_type_e mem_type_M;
  logic      proc2mngr_W;
  logic      rf_wen_X;
  logic      rf_wen_M;
  logic      rf_wen_pend_W;
  reg_addr_t rf_waddr_X;
  reg_addr_t rf_waddr_M;
  // stage advance
  logic      next_val_D;
  logic      next_val_X;
  logic      next_val_M;
  logic      stall_W;

  // ------------------------------
  // D decode and hazards
  // ------------------------------

  inst_decoder i_dec (
    .inst           (inst_D),
    .dec_val        (dec_val),
    .dec            (dec),
    .d_ctrl         (d_ctrl_D),
    .rs1_en         (rs1_en),
    .rs2_en         (rs2_en),
    .rs1            (rs1),
    .rs2            (rs2),
    .mngr2proc_read (mngr2proc_read_D)
  );

  hazard_detect i_haz (
    .rs1_en        (rs1_en),
    .rs2_en        (rs2_en),
    .rs1           (rs1),
    .rs2           (rs2),
    .val_X         (val_X),
    .val_M         (val_M),
    .val_W         (val_W),
    .rf_wen_X      (rf_wen_X),
    .rf_wen_M      (rf_wen_M),
    .rf_wen_pend_W (rf_wen_pend_W),
    .rf_waddr_X    (rf_waddr_X),
    .rf_waddr_M    (rf_waddr_M),
    .rf_waddr_W    (rf_waddr_W),
    .hazard        (hazard_D)
  );

  // ------------------------------
  // pipeline state and control
  // ------------------------------

  // port names match the wires above one for one
  stage_ctrl_regs i_regs (.*);

  pipe_ctrl i_pipe (.*);

  // alu function rides in the X control word
  assign alu_fn_X = x_ctrl.alu_fn;

endmodule

/* tb/tb_clock_gen.sv */
// ------------------------------
// testbench clock and reset
// 20 ns clock, reset held for 8 cycles
// ------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // released on the 8th rising edge
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* tb/proc_ctrl_tb.sv */
// ------------------------------
// control unit testbench
// per cycle vectors from tb/ctrl_input.txt
// ------------------------------
`timescale 1ns/1ps

module proc_ctrl_tb import proc_ctrl_pkg::*; ();

  // one cycle of stimulus and expected outputs
  typedef struct packed {
    logic [7:0] test;
    inst_t      inst;
    logic       ireq_rdy;
    logic       iresp_val;
    logic       dreq_rdy;
    logic       dresp_val;
    logic       m2p_val;
    logic       p2m_rdy;
    logic       br_eq;
    reg_en_t    en;
    pc_sel_e    pc_sel;
    logic       drop;
    logic       dreq_val;
    logic       dresp_rdy;
    logic       m2p_rdy;
    logic       p2m_val;
    wb_sel_e    wb_sel;
    reg_addr_t  waddr;
    logic       wen;
    logic       commit;
  } vec_t;

  logic      clk;
  logic      reset;
  logic      imem_reqstream_val;
  logic      imem_reqstream_rdy;
  logic      imem_respstream_val;
  logic      imem_respstream_rdy;
  logic      imem_respstream_drop;
  logic      dmem_reqstream_val;
  logic      dmem_reqstream_rdy;
  logic      dmem_respstream_val;
  logic      dmem_respstream_rdy;
  logic      mngr2proc_val;
  logic      mngr2proc_rdy;
  logic      proc2mngr_val;
  logic      proc2mngr_rdy;
  inst_t     inst_D;
  logic      br_cond_eq_X;
  reg_en_t   reg_en;
  pc_sel_e   pc_sel_F;
  d_ctrl_t   d_ctrl_D;
  alu_fn_e   alu_fn_X;
  wb_sel_e   wb_sel_M;
  reg_addr_t rf_waddr_W;
  logic      rf_wen_W;
  logic      commit_inst;

  vec_t vecs[$];
  int   checks;
  int   errors;
  int   test_errors;
  int   test_cycles;
  int   tests_done;
  bit   timed_out;
  bit   load_ok;

  tb_clock_gen i_clk (.clk(clk), .reset(reset));

  proc_ctrl i_dut (.*);

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s exp=%0b got=%0b", $time, name, exp, act);
    end
  endtask

  task automatic check_pc_sel(input string name, input pc_sel_e exp, input pc_sel_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s exp=%0d got=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t exp,
                                input reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s exp=%0d got=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_reg_en(input string name, input reg_en_t exp, input reg_en_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s exp=%b got=%b", $time, name, exp, act);
    end
  endtask

  task automatic check_d_ctrl(input string name, input d_ctrl_t exp, input d_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s exp=%b got=%b", $time, name, exp, act);
    end
  endtask

  task automatic check_alu_fn(input string name, input alu_fn_e exp, input alu_fn_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s exp=%0d got=%0d", $time, name, exp, act);
    end
  endtask

  // ------------------------------
  // reference selects
  // ------------------------------

  // selects from the RV32 opcode and funct fields
  // nop selects nothing and a branch leaves the alu unused
  task automatic reference_decode(input inst_t inst, output bit d_care, output d_ctrl_t d,
                                  output bit fn_care, output alu_fn_e fn);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    opcode     = inst[6:0];
    funct3     = inst[14:12];
    alt        = inst[30];
    d_care     = (inst != 32'h0000_0013);
    fn_care    = d_care;
    d.op2_sel  = op2_rf;
    d.imm_type = imm_i;
    fn         = alu_add;
    case (opcode)
      7'b0110011: begin
        case (funct3)
          3'b000:  fn = alt ? alu_sub : alu_add;
          3'b001:  fn = alu_sll;
          3'b010:  fn = alu_slt;
          3'b011:  fn = alu_sltu;
          3'b100:  fn = alu_xor;
          3'b101:  fn = alt ? alu_sra : alu_srl;
          3'b110:  fn = alu_or;
          default: fn = alu_and;
        endcase
      end
      // addi and lw add an i immediate
      7'b0010011, 7'b0000011: begin
        d.op2_sel = op2_imm;
      end
      7'b1100011: begin
        d.imm_type = imm_b;
        fn_care    = 1'b0;
      end
      // csrr copies the csr operand, csrw copies rs1
      7'b1110011: begin
        if (funct3 == 3'b010) begin
          d.op2_sel = op2_csr;
          fn        = alu_cp1;
        end else begin
          fn = alu_cp0;
        end
      end
      default: begin
        d_care  = 1'b0;
        fn_care = 1'b0;
      end
    endcase
  endtask

  // ------------------------------
  // vector file
  // ------------------------------

  task automatic load_vectors(output bit ok);
    int    fd;
    int    n;
    string line;
    vec_t  v;
    int    t, ins, ir, iv, dr, dv, mv, pr, be;
    int    en, pc, dp, dq, ds, mr, pv, wb, wa, we, cm;
    ok = 1'b0;
    fd = $fopen("tb/ctrl_input.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    t, ins, ir, iv, dr, dv, mv, pr, be,
                    en, pc, dp, dq, ds, mr, pv, wb, wa, we, cm);
        // comment lines start with #
        if (line.len() > 0 && line.getc(0) != "#" && n == 20) begin
          v.test      = t;
          v.inst      = ins;
          v.ireq_rdy  = ir;
          v.iresp_val = iv;
          v.dreq_rdy  = dr;
          v.dresp_val = dv;
          v.m2p_val   = mv;
          v.p2m_rdy   = pr;
          v.br_eq     = be;
          v.en        = en;
          v.pc_sel    = pc_sel_e'(pc);
          v.drop      = dp;
          v.dreq_val  = dq;
          v.dresp_rdy = ds;
          v.m2p_rdy   = mr;
          v.p2m_val   = pv;
          v.wb_sel    = wb_sel_e'(wb);
          v.waddr     = wa;
          v.wen       = we;
          v.commit    = cm;
          vecs.push_back(v);
        end
      end
      $fclose(fd);
      ok = (vecs.size() > 0);
    end
  endtask

  task automatic report_test(input int test);
    $display("test %0d: %s (%0d cycles, %0d errors)", test,
             (test_errors == 0) ? "ok" : "mismatch", test_cycles, test_errors);
    tests_done++;
    test_errors = 0;
    test_cycles = 0;
  endtask

  // drive 2 ns after the edge and sample 2 ns before the next one
  task automatic run_vectors();
    vec_t    v;
    int      cur;
    inst_t   x_inst;
    bit      x_known;
    bit      d_care;
    bit      fn_care;
    d_ctrl_t exp_d;
    alu_fn_e exp_fn;
    cur     = vecs[0].test;
    x_inst  = '0;
    x_known = 1'b0;
    @(negedge reset);
    #2;
    for (int i = 0; i < vecs.size(); i++) begin
      v = vecs[i];
      if (i > 0) begin
        @(posedge clk);
        #2;
      end
      if (v.test != cur) begin
        report_test(cur);
        cur = v.test;
      end
      inst_D              = v.inst;
      imem_reqstream_rdy  = v.ireq_rdy;
      imem_respstream_val = v.iresp_val;
      dmem_reqstream_rdy  = v.dreq_rdy;
      dmem_respstream_val = v.dresp_val;
      mngr2proc_val       = v.m2p_val;
      proc2mngr_rdy       = v.p2m_rdy;
      br_cond_eq_X        = v.br_eq;
      #16;
      test_cycles++;
      check_reg_en("reg_en", v.en, reg_en);
      check_pc_sel("pc_sel_F", v.pc_sel, pc_sel_F);
      check_bit("imem_respstream_drop", v.drop, imem_respstream_drop);
      check_bit("dmem_reqstream_val", v.dreq_val, dmem_reqstream_val);
      check_bit("dmem_respstream_rdy", v.dresp_rdy, dmem_respstream_rdy);
      check_bit("mngr2proc_rdy", v.m2p_rdy, mngr2proc_rdy);
      check_bit("proc2mngr_val", v.p2m_val, proc2mngr_val);
      check_bit("wb_sel_M", logic'(v.wb_sel), logic'(wb_sel_M));
      check_reg_addr("rf_waddr_W", v.waddr, rf_waddr_W);
      check_bit("rf_wen_W", v.wen, rf_wen_W);
      check_bit("commit_inst", v.commit, commit_inst);
      // with imem ready a fetch moves exactly when the pc does
      if (v.ireq_rdy) begin
        check_bit("imem_reqstream_val", v.en.f, imem_reqstream_val);
        check_bit("imem_respstream_rdy", v.en.f, imem_respstream_rdy);
      end
      reference_decode(v.inst, d_care, exp_d, fn_care, exp_fn);
      if (d_care) begin
        check_d_ctrl("d_ctrl_D", exp_d, d_ctrl_D);
      end
      // X holds the word that was in D at its last enabled edge
      if (x_known) begin
        reference_decode(x_inst, d_care, exp_d, fn_care, exp_fn);
        if (fn_care) begin
          check_alu_fn("alu_fn_X", exp_fn, alu_fn_X);
        end
      end
      if (v.en.x) begin
        x_inst  = v.inst;
        x_known = 1'b1;
      end
    end
    report_test(cur);
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------

  initial begin
    inst_D              = 32'h0000_0013;
    imem_reqstream_rdy  = 1'b1;
    imem_respstream_val = 1'b1;
    dmem_reqstream_rdy  = 1'b1;
    dmem_respstream_val = 1'b1;
    mngr2proc_val       = 1'b0;
    proc2mngr_rdy       = 1'b1;
    br_cond_eq_X        = 1'b0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    test_cycles = 0;
    tests_done  = 0;
    timed_out   = 1'b0;
    load_vectors(load_ok);
    if (!load_ok) begin
      $display("could not read any vectors from tb/ctrl_input.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      fork
        run_vectors();
        begin
          // vector cycles plus 40 cycles of slack at 20 ns each
          #((vecs.size() + 40) * 20);
          timed_out = 1'b1;
          $display("timeout: vectors did not finish in time");
        end
      join_any
      $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (timed_out || errors != 0) begin
        $display("CHECKS FAILED");
      end else begin
        $display("ALL CHECKS PASSED");
      end
      $finish;
    end
  end

endmodule

/* tb/ctrl_input.txt */
# test inst ireq_rdy iresp_val dreq_rdy dresp_val m2p_val p2m_rdy br_eq |
# exp: reg_en pc_sel drop dreq_val dresp_rdy m2p_rdy p2m_val wb_sel_M waddr_W wen_W commit
1 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 0
1 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 0
1 000000b3 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 0
1 00000133 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 0
1 000001b3 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 0
1 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 01 1 1
1 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 02 1 1
1 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 03 1 1
2 000000b3 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 1
2 00008233 1 1 1 1 0 1 0 07 0 0 0 0 0 0 0 00 0 1
2 00008233 1 1 1 1 0 1 0 07 0 0 0 0 0 0 0 00 0 1
2 00008233 1 1 1 1 0 1 0 07 0 0 0 0 0 0 0 01 1 1
2 00008233 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 04 0 0
2 00000033 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 04 0 0
2 000003b3 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 04 0 0
2 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 04 1 1
2 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 1 1
3 00001063 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 07 1 1
3 000002b3 1 1 1 1 0 1 0 1f 1 1 0 0 0 0 0 00 0 1
3 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 1
3 00001063 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 1
3 00000013 1 1 1 1 0 1 1 1f 0 0 0 0 0 0 0 05 0 0
3 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 0
4 00002403 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 1
4 00000013 1 1 0 1 0 1 0 03 0 0 0 0 0 0 0 00 0 1
4 00000013 1 1 1 1 0 1 0 1f 0 0 1 0 0 0 1 00 0 1
4 00000013 1 1 1 0 0 1 0 01 0 0 0 0 0 0 1 08 0 0
4 00000013 1 1 1 1 0 1 0 1f 0 0 0 1 0 0 1 08 0 0
5 7c001073 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 08 1 1
5 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 1
5 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 00 0 1
5 00000013 1 1 1 1 0 0 0 00 0 0 0 0 0 0 0 00 0 0
5 00000013 1 1 1 1 0 0 0 00 0 0 0 0 0 0 0 00 0 0
5 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 1 0 00 0 1
6 fc0024f3 1 1 1 1 0 1 0 07 0 0 0 0 0 0 0 00 0 1
6 fc0024f3 1 1 1 1 0 1 0 07 0 0 0 0 0 0 0 00 0 1
6 fc0024f3 1 1 1 1 1 1 0 1f 0 0 0 0 1 0 0 00 0 1
6 00000013 1 1 1 1 1 1 0 1f 0 0 0 0 0 0 0 09 0 0
6 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 09 0 0
6 00000013 1 1 1 1 0 1 0 1f 0 0 0 0 0 0 0 09 1 1

/* list.f */
verilog/proc_ctrl_pkg.sv
verilog/inst_decoder.sv
verilog/hazard_detect.sv
verilog/stage_ctrl_regs.sv
verilog/pipe_ctrl.sv
verilog/proc_ctrl.sv
tb/tb_clock_gen.sv
tb/proc_ctrl_tb.sv
